// File: include/bin_config.svh
`ifndef BIN_CONFIG_SVH
`define BIN_CONFIG_SVH

// active frame in pixels, both must be even
`define FRAME_W 16
`define FRAME_H 8

// binned frame, one bit per 2x2 block
`define BIN_W (`FRAME_W / 2)
`define BIN_H (`FRAME_H / 2)

// frame store entries
`define BIN_DEPTH (`BIN_W * `BIN_H)

// credits held by the source after reset
// also the depth of the input FIFO
`define PIX_CREDITS 4

// set mask bits needed out of four for a 1 bin
`define BIN_MIN_SET 2

`endif

// File: src/bin_pkg.sv
`include "bin_config.svh"

package bin_pkg;

  // widths derived from the frame size
  localparam int BIN_AW = (`BIN_DEPTH > 1) ? $clog2(`BIN_DEPTH) : 1;
  localparam int PX_XW  = (`FRAME_W > 1) ? $clog2(`FRAME_W) : 1;
  localparam int PX_YW  = (`FRAME_H > 1) ? $clog2(`FRAME_H) : 1;

  typedef logic [15:0] rgb565_t;  // r 15:11, g 10:5, b 4:0
  typedef logic [7:0] luma_t;
  typedef logic [BIN_AW-1:0] bin_addr_t;  // frame store address
  typedef logic [PX_XW-1:0] px_x_t;  // raster column
  typedef logic [PX_YW-1:0] px_y_t;  // raster row

  // readback client states
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_DATA
  } rd_state_e;

  // arbiter grant, one client per cycle at most
  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_WRITER,
    GNT_READER
  } grant_e;

endpackage

// File: src/mem_port_if.sv
`timescale 1ns/1ps

// one client port into the binned frame store
interface mem_port_if;
  import bin_pkg::*;

  logic      req;     // held by the client until gnt
  logic      we;      // 1 write, 0 read
  bin_addr_t addr;
  logic      wdata;
  logic      gnt;     // one cycle, access happens in this cycle
  logic      rdata;   // valid with rvalid
  logic      rvalid;  // one cycle after gnt of a read

  // requesting side
  modport client(output req, we, addr, wdata, input gnt, rdata, rvalid);

  // memory and arbiter side
  modport store(input req, we, addr, wdata, output gnt, rdata, rvalid);

endinterface

// File: src/pixel_credit_fifo.sv
`timescale 1ns/1ps
`include "bin_config.svh"

module pixel_credit_fifo (
  input  logic             clk_pixel,
  input  logic             sys_rst_pixel,
  input  logic             push_i,        // source spent a credit
  input  bin_pkg::rgb565_t push_data_i,
  input  logic             pop_i,         // threshold stage takes the head
  output logic             head_valid_o,
  output bin_pkg::rgb565_t head_data_o,
  output logic             credit_o       // one pulse per popped pixel
);
  import bin_pkg::*;

  localparam int DEPTH = `PIX_CREDITS;
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
  localparam int CW = $clog2(DEPTH + 1);                // count 0..DEPTH

  rgb565_t       buf_q [DEPTH];  // pixel slots
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;        // occupancy
  logic          do_pop;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_pop       = pop_i && head_valid_o;  // never pop an empty FIFO
  assign head_valid_o = (count_q != '0);
  assign head_data_o  = buf_q[rd_ptr_q];        // show-ahead head

  // the source never pushes without a credit, so a push always has room
  always_ff @(posedge clk_pixel) begin
    if (push_i) buf_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q  <= count_q + CW'(push_i) - CW'(do_pop);
      credit_o <= do_pop;  // credit back one cycle after the pop
    end
  end

endmodule

// File: src/mask_threshold.sv
`timescale 1ns/1ps
`include "bin_config.svh"

module mask_threshold (
  input  logic             clk_pixel,
  input  logic             sys_rst_pixel,
  input  logic             head_valid_i,
  input  bin_pkg::rgb565_t head_data_i,
  input  logic             stall_i,       // binner write waiting on the store
  input  bin_pkg::luma_t   luma_cutoff_i,
  output logic             pop_o,
  output logic             mask_valid_o,
  output logic             mask_o,
  output bin_pkg::px_x_t   x_o,           // raster position of mask_o
  output bin_pkg::px_y_t   y_o
);
  import bin_pkg::*;

  logic [7:0]  red8;
  logic [7:0]  green8;
  logic [7:0]  blue8;
  logic [10:0] luma_sum;  // 2r + 5g + b, max 2004
  luma_t       luma;
  px_x_t       x_cnt_q;   // position of the next popped pixel
  px_y_t       y_cnt_q;

  assign pop_o = head_valid_i && !stall_i;

  // widen each channel to 8 bits with zero fill
  assign red8   = {head_data_i[15:11], 3'b000};
  assign green8 = {head_data_i[10:5], 2'b00};
  assign blue8  = {head_data_i[4:0], 3'b000};

  assign luma_sum = (11'(red8) << 1) + (11'(green8) << 2) + 11'(green8) + 11'(blue8);
  assign luma     = luma_sum[10:3];  // divide by 8, truncated

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      mask_valid_o <= 1'b0;
      x_cnt_q      <= '0;
      y_cnt_q      <= '0;
    end else begin
      mask_valid_o <= pop_o;
      if (pop_o) begin
        if (x_cnt_q == px_x_t'(`FRAME_W - 1)) begin  // end of line
          x_cnt_q <= '0;
          y_cnt_q <= (y_cnt_q == px_y_t'(`FRAME_H - 1)) ? '0 : y_cnt_q + 1'b1;
        end else begin
          x_cnt_q <= x_cnt_q + 1'b1;
        end
      end
    end
  end

  // mask bit and its position, qualified by mask_valid_o
  always_ff @(posedge clk_pixel) begin
    if (pop_o) begin
      mask_o <= (luma >= luma_cutoff_i);  // cutoff is inclusive
      x_o    <= x_cnt_q;
      y_o    <= y_cnt_q;
    end
  end

endmodule

// File: src/bin_accumulator.sv
`timescale 1ns/1ps
`include "bin_config.svh"

module bin_accumulator (
  input  logic           clk_pixel,
  input  logic           sys_rst_pixel,
  input  logic           mask_valid_i,
  input  logic           mask_i,
  input  bin_pkg::px_x_t x_i,
  input  bin_pkg::px_y_t y_i,
  mem_port_if.client     wr_port,       // write side of the frame store
  output logic           stall_o,       // holds off the threshold stage
  output logic           frame_done_o   // last bin of the frame granted
);
  import bin_pkg::*;

  localparam int HXW = $bits(px_x_t) - 1;  // width of x/2

  logic [1:0]     line_buf [`BIN_W];  // pair sums from the even row
  logic           left_q;             // even column bit of the current pair
  logic [HXW-1:0] half_x;             // bin column
  logic [1:0]     pair_sum;
  logic [2:0]     bin_sum;            // 0..4 set bits
  logic           odd_col;
  logic           odd_row;
  logic           bin_done;           // bottom right pixel of a bin
  logic           last_bin;
  logic           req_q;
  bin_addr_t      addr_q;
  logic           data_q;
  logic           last_q;             // pending write is the frame's last bin

  assign half_x   = x_i[HXW:1];
  assign odd_col  = x_i[0];
  assign odd_row  = y_i[0];
  assign pair_sum = {1'b0, left_q} + {1'b0, mask_i};
  assign bin_sum  = {1'b0, line_buf[half_x]} + {1'b0, pair_sum};
  assign bin_done = mask_valid_i && odd_col && odd_row;
  assign last_bin = (x_i == px_x_t'(`FRAME_W - 1)) && (y_i == px_y_t'(`FRAME_H - 1));

  // pair sums and the fields of the pending write
  always_ff @(posedge clk_pixel) begin
    if (mask_valid_i && !odd_col) left_q <= mask_i;
    if (mask_valid_i && odd_col && !odd_row) begin
      line_buf[half_x] <= pair_sum;  // top half of the bin
    end
    if (bin_done) begin
      addr_q <= bin_addr_t'((y_i >> 1) * `BIN_W + half_x);  // (y/2)*BIN_W + x/2
      data_q <= (bin_sum >= 3'(`BIN_MIN_SET));
      last_q <= last_bin;
    end
  end

  // request stays up until the store grants it
  // no new bin can finish while one waits since the stall blocks the pop
  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      req_q <= 1'b0;
    end else if (bin_done) begin
      req_q <= 1'b1;
    end else if (wr_port.gnt) begin
      req_q <= 1'b0;
    end
  end

  assign wr_port.req   = req_q;
  assign wr_port.we    = 1'b1;  // this client only writes
  assign wr_port.addr  = addr_q;
  assign wr_port.wdata = data_q;

  assign stall_o      = req_q && !wr_port.gnt;
  assign frame_done_o = req_q && wr_port.gnt && last_q;

endmodule

// File: src/bin_reader.sv
`timescale 1ns/1ps

module bin_reader (
  input  logic               clk_pixel,
  input  logic               sys_rst_pixel,
  input  logic               rd_req_i,    // ignored while busy
  input  bin_pkg::bin_addr_t rd_addr_i,
  mem_port_if.client         rd_port,
  output logic               rd_busy_o,
  output logic               rd_valid_o,  // one cycle, rd_bit_o valid
  output logic               rd_bit_o
);
  import bin_pkg::*;

  rd_state_e state_q;
  bin_addr_t addr_q;  // captured on accept

  assign rd_port.req   = (state_q == WAIT_GNT);
  assign rd_port.we    = 1'b0;  // read only client
  assign rd_port.addr  = addr_q;
  assign rd_port.wdata = 1'b0;
  assign rd_busy_o     = (state_q != IDLE);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      state_q    <= IDLE;
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= 1'b0;
      case (state_q)
        IDLE:      if (rd_req_i) state_q <= WAIT_GNT;
        WAIT_GNT:  if (rd_port.gnt) state_q <= WAIT_DATA;  // writer may hold us off
        WAIT_DATA: if (rd_port.rvalid) begin
          state_q    <= IDLE;
          rd_valid_o <= 1'b1;
        end
        default:   state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (state_q == IDLE && rd_req_i) addr_q <= rd_addr_i;
    if (state_q == WAIT_DATA && rd_port.rvalid) rd_bit_o <= rd_port.rdata;
  end

endmodule

// File: src/bin_frame_store.sv
`timescale 1ns/1ps
`include "bin_config.svh"

module bin_frame_store (
  input  logic     clk_pixel,
  input  logic     sys_rst_pixel,
  mem_port_if.store wr_port,  // binner, high priority
  mem_port_if.store rd_port   // readback
);
  import bin_pkg::*;

  logic      mem [`BIN_DEPTH];  // binned frame, contents survive reset
  grant_e    grant_q;           // client served this cycle
  grant_e    grant_d;
  logic      sel_rd;
  logic      acc_en;
  logic      acc_we;
  bin_addr_t acc_addr;
  logic      acc_wdata;
  logic      rdata_q;
  logic      wr_rvalid_q;
  logic      rd_rvalid_q;

  // fixed priority, a client granted this cycle still shows req so skip it
  always_comb begin
    if (wr_port.req && grant_q != GNT_WRITER) begin
      grant_d = GNT_WRITER;
    end else if (rd_port.req && grant_q != GNT_READER) begin
      grant_d = GNT_READER;
    end else begin
      grant_d = GNT_NONE;
    end
  end

  // mux the granted client onto the array
  assign sel_rd    = (grant_q == GNT_READER);
  assign acc_en    = (grant_q != GNT_NONE);
  assign acc_we    = sel_rd ? rd_port.we : wr_port.we;
  assign acc_addr  = sel_rd ? rd_port.addr : wr_port.addr;
  assign acc_wdata = sel_rd ? rd_port.wdata : wr_port.wdata;

  always_ff @(posedge clk_pixel) begin
    if (acc_en && acc_we) mem[acc_addr] <= acc_wdata;
    if (acc_en && !acc_we) rdata_q <= mem[acc_addr];  // out the cycle after gnt
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      grant_q     <= GNT_NONE;
      wr_rvalid_q <= 1'b0;
      rd_rvalid_q <= 1'b0;
    end else begin
      grant_q     <= grant_d;
      wr_rvalid_q <= (grant_q == GNT_WRITER) && !wr_port.we;
      rd_rvalid_q <= (grant_q == GNT_READER) && !rd_port.we;
    end
  end

  assign wr_port.gnt    = (grant_q == GNT_WRITER);
  assign rd_port.gnt    = (grant_q == GNT_READER);
  assign wr_port.rdata  = rdata_q;  // shared read register
  assign rd_port.rdata  = rdata_q;
  assign wr_port.rvalid = wr_rvalid_q;
  assign rd_port.rvalid = rd_rvalid_q;

endmodule

// File: src/mask_binner_top.sv
`timescale 1ns/1ps

module mask_binner_top (
  input  logic               clk_pixel,
  input  logic               sys_rst_pixel,
  input  logic               pix_valid_i,    // only while a credit is held
  input  bin_pkg::rgb565_t   pix_data_i,
  input  bin_pkg::luma_t     luma_cutoff_i,
  input  logic               rd_req_i,
  input  bin_pkg::bin_addr_t rd_addr_i,
  output logic               credit_o,
  output logic               rd_busy_o,
  output logic               rd_valid_o,
  output logic               rd_bit_o,
  output logic               frame_done_o
);
  import bin_pkg::*;

  // FIFO to threshold
  logic    head_valid;
  rgb565_t head_data;
  logic    pop;

  // threshold to binner
  logic    mask_valid;
  logic    mask;
  px_x_t   mask_x;
  px_y_t   mask_y;
  logic    stall;  // binner write pending, freeze the pops

  mem_port_if wr_port ();  // binner to store
  mem_port_if rd_port ();  // readback to store

  pixel_credit_fifo i_fifo (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .push_i       (pix_valid_i),
    .push_data_i  (pix_data_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_data_o  (head_data),
    .credit_o     (credit_o)
  );

  mask_threshold i_threshold (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .head_valid_i (head_valid),
    .head_data_i  (head_data),
    .stall_i      (stall),
    .luma_cutoff_i(luma_cutoff_i),
    .pop_o        (pop),
    .mask_valid_o (mask_valid),
    .mask_o       (mask),
    .x_o          (mask_x),
    .y_o          (mask_y)
  );

  bin_accumulator i_binner (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .mask_valid_i (mask_valid),
    .mask_i       (mask),
    .x_i          (mask_x),
    .y_i          (mask_y),
    .wr_port      (wr_port),
    .stall_o      (stall),
    .frame_done_o (frame_done_o)
  );

  bin_reader i_reader (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .rd_req_i     (rd_req_i),
    .rd_addr_i    (rd_addr_i),
    .rd_port      (rd_port),
    .rd_busy_o    (rd_busy_o),
    .rd_valid_o   (rd_valid_o),
    .rd_bit_o     (rd_bit_o)
  );

  bin_frame_store i_store (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .wr_port      (wr_port),
    .rd_port      (rd_port)
  );

endmodule

// File: testbench/mask_binner_assert.sv
`timescale 1ns/1ps
`include "bin_config.svh"

module mask_binner_assert (
  input logic clk_pixel,
  input logic sys_rst_pixel,
  input logic pix_valid_i,
  input logic credit_o,
  input logic wr_gnt_i,  // frame store grant to the binner
  input logic rd_gnt_i   // frame store grant to the readback client
);
  int outstanding_q;  // pixels pushed but not yet credited back

  always_ff @(posedge clk_pixel) begin
    if (sys_rst_pixel) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(pix_valid_i) - int'(credit_o);
    end
  end

  // the source may never spend more than it was given
  credit_bound: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    outstanding_q <= `PIX_CREDITS)
    else $error("more credits outstanding than the FIFO holds");

  // arbiter serves one client per cycle
  single_grant: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
    !(wr_gnt_i && rd_gnt_i))
    else $error("frame store granted both ports in one cycle");

endmodule

bind mask_binner_top mask_binner_assert i_assert (
  .clk_pixel    (clk_pixel),
  .sys_rst_pixel(sys_rst_pixel),
  .pix_valid_i  (pix_valid_i),
  .credit_o     (credit_o),
  .wr_gnt_i     (wr_port.gnt),
  .rd_gnt_i     (rd_port.gnt)
);

// File: testbench/tb_mask_binner.sv
`timescale 1ns/1ps
`include "bin_config.svh"

module tb_mask_binner;
  import bin_pkg::*;

  localparam int NPIX    = `FRAME_W * `FRAME_H;
  localparam int TIMEOUT = 2000;  // cycles allowed per wait

  logic      clk_pixel;
  logic      sys_rst_pixel;
  logic      pix_valid_i;
  rgb565_t   pix_data_i;
  luma_t     luma_cutoff_i;
  logic      rd_req_i;
  bin_addr_t rd_addr_i;
  logic      credit_o;
  logic      rd_busy_o;
  logic      rd_valid_o;
  logic      rd_bit_o;
  logic      frame_done_o;

  rgb565_t frame [NPIX];           // frame under test in raster order
  logic    exp_bins [`BIN_DEPTH];  // expected store contents
  logic    seen_one [`BIN_DEPTH];  // bins already read back as 1
  int      sent_cnt;
  int      credit_cnt;             // credit_o pulses seen
  int      done_cnt;               // frame_done_o pulses seen
  int      err_cnt;
  bit      stream_done;

  mask_binner_top i_mask_binner_top (.*);

  initial begin
    clk_pixel = 1'b0;
    forever #2 clk_pixel = ~clk_pixel;
  end

  // outputs are settled by the falling edge
  always @(negedge clk_pixel) begin
    if (credit_o) credit_cnt++;
    if (frame_done_o) done_cnt++;
  end

  task automatic report_error(input string line);
    err_cnt++;
    $display("%s", line);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_error($sformatf("CHECK FAILED at %0t: %s, got %0h expected %0h",
                                  $time, what, got, exp));
  endtask

  task automatic step_cycle();
    @(posedge clk_pixel);
    #1;  // drive just after the edge
  endtask

  task automatic apply_reset();
    sys_rst_pixel = 1'b1;
    repeat (5) @(posedge clk_pixel);
    #1 sys_rst_pixel = 1'b0;
  endtask

  // spends one credit and waits while none is held
  task automatic send_pixel(input rgb565_t px);
    int waited;
    waited = 0;
    while (sent_cnt - credit_cnt >= `PIX_CREDITS) begin
      step_cycle();
      waited++;
      if (waited > TIMEOUT) report_error("no credit came back, source is stuck");
    end
    pix_valid_i = 1'b1;
    pix_data_i  = px;
    sent_cnt++;
    step_cycle();
    pix_valid_i = 1'b0;
  endtask

  // whole frame with optional random idle cycles between pixels
  task automatic run_frame(input int max_gap);
    int target;
    int waited;
    target = done_cnt + 1;
    waited = 0;
    for (int i = 0; i < NPIX; i++) begin
      send_pixel(frame[i]);
      if (max_gap > 0) repeat ($urandom_range(max_gap, 0)) step_cycle();
    end
    while (done_cnt < target) begin
      step_cycle();
      waited++;
      if (waited > TIMEOUT) report_error("frame_done_o never pulsed for the frame");
    end
  endtask

  // drained once credit_o has stayed low for a while
  task automatic wait_drain();
    int waited;
    int quiet;
    waited = 0;
    quiet  = 0;
    while (quiet < 8) begin
      step_cycle();
      quiet = credit_o ? 0 : quiet + 1;
      waited++;
      if (waited > TIMEOUT) report_error("credit_o kept pulsing, stream never drained");
    end
  endtask

  task automatic read_bin(input bin_addr_t addr, output logic got);
    int waited;
    waited    = 0;
    rd_req_i  = 1'b1;
    rd_addr_i = addr;
    step_cycle();
    rd_req_i = 1'b0;
    while (!rd_valid_o) begin
      check_eq("rd_busy_o while a read is open", rd_busy_o, 1'b1);
      step_cycle();
      waited++;
      if (waited > TIMEOUT) report_error("rd_valid_o never came back for a read");
    end
    got = rd_bit_o;
  endtask

  function automatic int ref_luma(input rgb565_t px);
    int r8;
    int g8;
    int b8;
    r8 = int'(px[15:11]) * 8;  // zero fill to 8 bits
    g8 = int'(px[10:5]) * 4;
    b8 = int'(px[4:0]) * 8;
    return (2 * r8 + 5 * g8 + b8) / 8;
  endfunction

  // mask each pixel and count set bits per 2x2 block
  task automatic build_model(input luma_t cutoff);
    int cnt;
    int idx;
    for (int by = 0; by < `BIN_H; by++) begin
      for (int bx = 0; bx < `BIN_W; bx++) begin
        cnt = 0;
        for (int k = 0; k < 4; k++) begin
          idx = (2 * by + k / 2) * `FRAME_W + 2 * bx + k % 2;
          if (ref_luma(frame[idx]) >= int'(cutoff)) cnt++;
        end
        exp_bins[by * `BIN_W + bx] = (cnt >= `BIN_MIN_SET);
      end
    end
  endtask

  task automatic expect_all(input logic v);
    for (int a = 0; a < `BIN_DEPTH; a++) exp_bins[a] = v;
  endtask

  task automatic check_readback(input string what);
    logic got;
    for (int a = 0; a < `BIN_DEPTH; a++) begin
      read_bin(bin_addr_t'(a), got);
      check_eq($sformatf("%s, bin %0d", what, a), got, exp_bins[a]);
    end
  endtask

  initial begin
    logic got;
    luma_t cutoff;
    int d0;
    int s0;
    int c0;
    int ra;
    void'($urandom(32'h5160110b));
    pix_valid_i   = 1'b0;
    pix_data_i    = '0;
    luma_cutoff_i = 8'd128;
    rd_req_i      = 1'b0;
    rd_addr_i     = '0;
    apply_reset();

    // test 1 checks quiet outputs and then a full credit burst
    repeat (8) begin
      check_eq("outputs low after reset", {credit_o, rd_valid_o, rd_busy_o, frame_done_o}, 0);
      step_cycle();
    end
    for (int i = 0; i < `PIX_CREDITS; i++) send_pixel(16'h0000);
    // a credit comes back two cycles after its push so the last two are still out
    check_eq("credits back by the end of the burst", credit_cnt,
             (`PIX_CREDITS > 2) ? `PIX_CREDITS - 2 : 0);
    wait_drain();
    check_eq("credits returned after the burst", credit_cnt, `PIX_CREDITS);
    apply_reset();  // raster back to 0,0

    // test 2 with solid frames
    for (int i = 0; i < NPIX; i++) frame[i] = 16'hffff;
    d0 = done_cnt;
    run_frame(0);
    expect_all(1'b1);
    check_readback("white frame");
    check_eq("frame_done pulses, white frame", done_cnt, d0 + 1);
    for (int i = 0; i < NPIX; i++) frame[i] = 16'h0000;
    run_frame(0);
    expect_all(1'b0);
    check_readback("black frame");
    check_eq("frame_done pulses, black frame", done_cnt, d0 + 2);

    // test 3 with random pixels and cutoff
    for (int i = 0; i < NPIX; i++) frame[i] = rgb565_t'($urandom);
    cutoff        = luma_t'($urandom_range(220, 40));
    luma_cutoff_i = cutoff;
    build_model(cutoff);
    run_frame(0);
    check_readback("random frame");

    // test 4 sweeps the cutoff on a fixed frame
    for (int i = 0; i < NPIX; i++) frame[i] = rgb565_t'(i * 16'h0bd3 + 16'h1111);
    frame[0]      = 16'hffff;  // brightest pixel possible
    luma_cutoff_i = 8'd0;
    build_model(8'd0);
    run_frame(0);
    check_readback("cutoff 0");
    luma_cutoff_i = 8'd255;
    build_model(8'd255);
    run_frame(0);
    check_readback("cutoff 255");

    // test 5 races reads against a full rate stream on an all zero store
    for (int i = 0; i < NPIX; i++) frame[i] = rgb565_t'($urandom);
    luma_cutoff_i = 8'd100;
    build_model(8'd100);
    for (int a = 0; a < `BIN_DEPTH; a++) seen_one[a] = 1'b0;
    stream_done = 1'b0;
    fork
      begin
        run_frame(0);
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          ra = $urandom_range(`BIN_DEPTH - 1, 0);
          read_bin(bin_addr_t'(ra), got);
          if (seen_one[ra]) begin
            // once written a bin stays set
            check_eq($sformatf("read of bin %0d while streaming", ra), got, 1'b1);
          end else if (!exp_bins[ra]) begin
            // a bin that is 0 in the new frame never turns on
            check_eq($sformatf("read of bin %0d while streaming", ra), got, 1'b0);
          end
          if (got) seen_one[ra] = 1'b1;
        end
      end
    join
    wait_drain();
    check_eq("pixels lost under contention", credit_cnt, sent_cnt);
    check_readback("contention frame");

    // test 6 sends two frames with random gaps
    s0 = sent_cnt;
    c0 = credit_cnt;
    for (int f = 0; f < 2; f++) begin
      for (int i = 0; i < NPIX; i++) frame[i] = rgb565_t'($urandom);
      run_frame(3);
    end
    build_model(luma_cutoff_i);  // last frame only
    wait_drain();
    check_eq("credit pulses against pixels sent", credit_cnt - c0, sent_cnt - s0);
    check_readback("gapped frame");

    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+include
src/bin_pkg.sv
src/mem_port_if.sv
src/pixel_credit_fifo.sv
src/mask_threshold.sv
src/bin_accumulator.sv
src/bin_reader.sv
src/bin_frame_store.sv
src/mask_binner_top.sv
testbench/mask_binner_assert.sv
testbench/tb_mask_binner.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mask binner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mask_binner -f list.f -o tb_sim

sim_out=$(./obj_dir/tb_sim) || true
echo "$sim_out"

if grep -q "All tests passed!" <<< "$sim_out"; then
  exit 0
fi
exit 1
